//--- hw/apb_map_pkg.sv
package apb_map_pkg;

    // register index after address decode
    typedef enum logic [2:0] {
        REG_OPA,
        REG_OPB,
        REG_CTRL,
        REG_STATUS,
        REG_RES_LO,
        REG_RES_HI,
        REG_NONE        // unmapped offset
    } mdu_reg_e;

    // phase and direction of the current bus cycle
    typedef enum logic [1:0] {
        APB_IDLE,
        APB_SETUP,
        APB_RD,         // access phase, read
        APB_WR          // access phase, write
    } apb_acc_e;

endpackage

//--- hw/mdu_apb_regs.sv
`timescale 1ns/1ns
`include "mdu_cfg.svh"

module mdu_apb_regs
    import mdu_pkg::*;
    import apb_map_pkg::*;
(
    input  logic                   clk,
    input  logic                   rst_n,
    input  logic                   psel,
    input  logic                   penable,
    input  logic                   pwrite,
    input  logic [`MDU_AW-1:0]     paddr,
    input  logic [31:0]            pwdata,
    output logic [31:0]            prdata,
    output logic                   pready,
    output logic                   pslverr,
    output logic                   mul_start,
    output logic                   mul_signed,
    output logic [`MDU_XLEN-1:0]   mul_a,
    output logic [`MDU_XLEN-1:0]   mul_b,
    input  logic                   mul_done,
    input  logic [2*`MDU_XLEN-1:0] mul_product,
    output logic                   div_start,
    output logic                   div_signed,
    output logic [`MDU_XLEN-1:0]   div_a,
    output logic [`MDU_XLEN-1:0]   div_b,
    input  logic                   div_done,
    input  logic [`MDU_XLEN-1:0]   div_quotient,
    input  logic [`MDU_XLEN-1:0]   div_remainder,
    input  logic                   div_zero
);

    mdu_reg_e    reg_sel;
    apb_acc_e    acc_kind;
    mdu_op_e     op_q;
    mdu_op_e     new_op;
    mdu_status_t st_q;
    mdu_word_t   opa_q;
    mdu_word_t   opb_q;
    mdu_word_t   res_lo_q;
    mdu_word_t   res_hi_q;
    logic        in_access;
    logic        wr_ok;
    logic        launch;
    logic        rd_status;

    always_comb
    begin
        case (paddr)
            `MDU_OFF_OPA:    reg_sel = REG_OPA;
            `MDU_OFF_OPB:    reg_sel = REG_OPB;
            `MDU_OFF_CTRL:   reg_sel = REG_CTRL;
            `MDU_OFF_STATUS: reg_sel = REG_STATUS;
            `MDU_OFF_RES_LO: reg_sel = REG_RES_LO;
            `MDU_OFF_RES_HI: reg_sel = REG_RES_HI;
            default:         reg_sel = REG_NONE;
        endcase
    end

    always_comb
    begin
        if (!psel)
            acc_kind = APB_IDLE;
        else if (!penable)
            acc_kind = APB_SETUP;
        else if (pwrite)
            acc_kind = APB_WR;
        else
            acc_kind = APB_RD;
    end

    assign in_access = (acc_kind == APB_WR) || (acc_kind == APB_RD);
    assign pready    = 1'b1;   // no wait states

    // unmapped offset, or a second launch while one is in flight
    assign pslverr = in_access && ((reg_sel == REG_NONE) ||
                     ((acc_kind == APB_WR) && (reg_sel == REG_CTRL) && st_q.busy));

    assign wr_ok     = (acc_kind == APB_WR) && !pslverr;
    assign launch    = wr_ok && (reg_sel == REG_CTRL);
    assign rd_status = (acc_kind == APB_RD) && (reg_sel == REG_STATUS);
    assign new_op    = mdu_op_e'(pwdata[1:0]);

    always_ff @(posedge clk)
    begin
        if (!rst_n)
        begin
            opa_q <= '0;
            opb_q <= '0;
            op_q  <= MUL;
        end
        else if (wr_ok)
        begin
            if (reg_sel == REG_OPA)
                opa_q <= pwdata;
            if (reg_sel == REG_OPB)
                opb_q <= pwdata;
            if (reg_sel == REG_CTRL)
                op_q <= new_op;
        end
    end

    always_ff @(posedge clk)
    begin
        if (!rst_n)
        begin
            mul_start <= 1'b0;
            div_start <= 1'b0;
        end
        else
        begin
            mul_start <= launch & ~new_op[1];   // one cycle pulses
            div_start <= launch & new_op[1];
        end
    end

    always_ff @(posedge clk)
    begin
        if (!rst_n)
        begin
            st_q <= '0;
        end
        else if (launch)
        begin
            st_q.busy     <= 1'b1;
            st_q.done     <= 1'b0;
            st_q.div_zero <= 1'b0;
        end
        else if (mul_done || div_done)
        begin
            st_q.busy     <= 1'b0;
            st_q.done     <= 1'b1;
            st_q.div_zero <= div_done & div_zero;
        end
        else if (rd_status)
        begin
            st_q.done <= 1'b0;       // read clears done
        end
    end

    always_ff @(posedge clk)
    begin
        if (!rst_n)
        begin
            res_lo_q <= '0;
            res_hi_q <= '0;
        end
        else if (mul_done)
        begin
            {res_hi_q, res_lo_q} <= mul_product;
        end
        else if (div_done)
        begin
            res_lo_q <= div_quotient;
            res_hi_q <= div_remainder;
        end
    end

    assign mul_signed = ~op_q[0];
    assign div_signed = ~op_q[0];
    assign mul_a      = opa_q;
    assign mul_b      = opb_q;
    assign div_a      = opa_q;   // dividend
    assign div_b      = opb_q;   // divisor

    always_comb
    begin
        prdata = '0;
        if (acc_kind == APB_RD)
        begin
            case (reg_sel)
                REG_OPA:    prdata = opa_q;
                REG_OPB:    prdata = opb_q;
                REG_CTRL:   prdata = 32'(op_q);
                REG_STATUS: prdata = 32'(st_q);   // zero-extended
                REG_RES_LO: prdata = res_lo_q;
                REG_RES_HI: prdata = res_hi_q;
                default:    prdata = '0;
            endcase
        end
    end

endmodule

//--- hw/mdu_cfg.svh
`ifndef MDU_CFG_SVH
`define MDU_CFG_SVH

`define MDU_XLEN        32      // operand width, results are twice this
`define MDU_AW          8       // apb address width

`define MDU_OFF_OPA     8'h00
`define MDU_OFF_OPB     8'h04
`define MDU_OFF_CTRL    8'h08
`define MDU_OFF_STATUS  8'h0C
`define MDU_OFF_RES_LO  8'h10
`define MDU_OFF_RES_HI  8'h14

`endif

//--- hw/mdu_pkg.sv
`include "mdu_cfg.svh"

package mdu_pkg;

    typedef logic [`MDU_XLEN-1:0]   mdu_word_t;
    typedef logic [2*`MDU_XLEN-1:0] mdu_dword_t;

    // bit 1 picks the divider, bit 0 means unsigned
    typedef enum logic [1:0] {
        MUL  = 2'b00,
        MULU = 2'b01,
        DIV  = 2'b10,
        DIVU = 2'b11
    } mdu_op_e;

    typedef struct packed {
        logic div_zero;     // bit 2
        logic done;         // bit 1
        logic busy;         // bit 0
    } mdu_status_t;

    // magnitude of v, raw value when unsigned
    function automatic mdu_word_t mdu_mag(input mdu_word_t v, input logic signed_op);
        return (signed_op && v[`MDU_XLEN-1]) ? -v : v;
    endfunction

endpackage

//--- hw/mdu_top.sv
`timescale 1ns/1ns
`include "mdu_cfg.svh"

module mdu_top
    import mdu_pkg::*;
(
    input  logic               clk,
    input  logic               rst_n,
    input  logic               psel,
    input  logic               penable,
    input  logic               pwrite,
    input  logic [`MDU_AW-1:0] paddr,
    input  logic [31:0]        pwdata,
    output logic [31:0]        prdata,
    output logic               pready,
    output logic               pslverr
);

    logic       mul_start;
    logic       mul_signed;
    mdu_word_t  mul_a;
    mdu_word_t  mul_b;
    logic       mul_done;
    mdu_dword_t mul_product;
    logic       div_start;
    logic       div_signed;
    mdu_word_t  div_a;
    mdu_word_t  div_b;
    logic       div_done;
    mdu_word_t  div_quotient;
    mdu_word_t  div_remainder;
    logic       div_zero;

    mdu_apb_regs i_regs (
        .clk           (clk),
        .rst_n         (rst_n),
        .psel          (psel),
        .penable       (penable),
        .pwrite        (pwrite),
        .paddr         (paddr),
        .pwdata        (pwdata),
        .prdata        (prdata),
        .pready        (pready),
        .pslverr       (pslverr),
        .mul_start     (mul_start),
        .mul_signed    (mul_signed),
        .mul_a         (mul_a),
        .mul_b         (mul_b),
        .mul_done      (mul_done),
        .mul_product   (mul_product),
        .div_start     (div_start),
        .div_signed    (div_signed),
        .div_a         (div_a),
        .div_b         (div_b),
        .div_done      (div_done),
        .div_quotient  (div_quotient),
        .div_remainder (div_remainder),
        .div_zero      (div_zero)
    );

    shift_add_mul i_mul (
        .clk       (clk),
        .rst_n     (rst_n),
        .start     (mul_start),
        .signed_op (mul_signed),
        .a         (mul_a),
        .b         (mul_b),
        .done      (mul_done),
        .product   (mul_product)
    );

    restoring_div i_div (
        .clk       (clk),
        .rst_n     (rst_n),
        .start     (div_start),
        .signed_op (div_signed),
        .dividend  (div_a),
        .divisor   (div_b),
        .done      (div_done),
        .quotient  (div_quotient),
        .remainder (div_remainder),
        .div_zero  (div_zero)
    );

endmodule

//--- hw/restoring_div.sv
`timescale 1ns/1ns
`include "mdu_cfg.svh"

module restoring_div
    import mdu_pkg::*;
(
    input  logic                 clk,
    input  logic                 rst_n,
    input  logic                 start,
    input  logic                 signed_op,
    input  logic [`MDU_XLEN-1:0] dividend,
    input  logic [`MDU_XLEN-1:0] divisor,
    output logic                 done,
    output logic [`MDU_XLEN-1:0] quotient,
    output logic [`MDU_XLEN-1:0] remainder,
    output logic                 div_zero
);

    localparam int XL = `MDU_XLEN;
    localparam int CW = $clog2(XL + 1);

    mdu_word_t     rem_q;       // partial remainder
    mdu_word_t     quo_q;       // dividend bits shift out, quotient bits shift in
    mdu_word_t     dvs_q;       // divisor magnitude
    mdu_word_t     dvd_q;       // raw dividend for the zero divisor case
    logic [CW-1:0] cnt;
    logic          active;
    logic          q_neg;
    logic          r_neg;       // remainder follows dividend sign
    logic          zero_q;
    logic          ovf_q;       // most negative / -1
    logic [XL:0]   shifted;
    logic [XL:0]   diff;

    assign shifted = {rem_q, quo_q[XL-1]};
    assign diff    = shifted - {1'b0, dvs_q};
    assign done    = active & (cnt == '0);

    always_ff @(posedge clk)
    begin
        if (!rst_n)
        begin
            active <= 1'b0;
            cnt    <= '0;
        end
        else if (start)
        begin
            active <= 1'b1;
            cnt    <= CW'(XL);
        end
        else if (active)
        begin
            if (cnt == '0)
                active <= 1'b0;
            else
                cnt <= cnt - 1'b1;
        end
    end

    always_ff @(posedge clk)
    begin
        if (start)
        begin
            rem_q  <= '0;
            quo_q  <= mdu_mag(dividend, signed_op);
            dvs_q  <= mdu_mag(divisor, signed_op);
            dvd_q  <= dividend;
            q_neg  <= signed_op & (dividend[XL-1] ^ divisor[XL-1]);
            r_neg  <= signed_op & dividend[XL-1];
            zero_q <= (divisor == '0);
            ovf_q  <= signed_op & (dividend == {1'b1, {(XL-1){1'b0}}}) & (&divisor);
        end
        else if (active && (cnt != '0))
        begin
            if (!diff[XL])      // no borrow, keep the difference
            begin
                rem_q <= diff[XL-1:0];
                quo_q <= {quo_q[XL-2:0], 1'b1};
            end
            else                // restore
            begin
                rem_q <= shifted[XL-1:0];
                quo_q <= {quo_q[XL-2:0], 1'b0};
            end
        end
    end

    always_comb
    begin
        if (zero_q)
        begin
            quotient  = '1;
            remainder = dvd_q;
        end
        else if (ovf_q)
        begin
            quotient  = {1'b1, {(XL-1){1'b0}}};
            remainder = '0;
        end
        else
        begin
            quotient  = q_neg ? -quo_q : quo_q;   // truncates toward zero
            remainder = r_neg ? -rem_q : rem_q;
        end
    end

    assign div_zero = zero_q;

endmodule

//--- hw/shift_add_mul.sv
`timescale 1ns/1ns
`include "mdu_cfg.svh"

module shift_add_mul
    import mdu_pkg::*;
(
    input  logic                   clk,
    input  logic                   rst_n,
    input  logic                   start,
    input  logic                   signed_op,
    input  logic [`MDU_XLEN-1:0]   a,
    input  logic [`MDU_XLEN-1:0]   b,
    output logic                   done,
    output logic [2*`MDU_XLEN-1:0] product
);

    localparam int XL = `MDU_XLEN;

    mdu_dword_t mcand;          // magnitude of a, shifts left
    mdu_word_t  mplier;         // magnitude of b, shifts right
    mdu_dword_t acc;            // running sum of partial products
    mdu_dword_t partial;
    logic       neg;            // product sign
    logic       active;

    assign partial = mplier[0] ? mcand : '0;

    // finished once every set bit of the multiplier is consumed
    assign done = active & ~(|mplier);

    always_ff @(posedge clk)
    begin
        if (!rst_n)
        begin
            active <= 1'b0;
        end
        else if (start)
        begin
            active <= 1'b1;
        end
        else if (done)
        begin
            active <= 1'b0;
        end
    end

    always_ff @(posedge clk)
    begin
        if (start)
        begin
            mcand  <= {{XL{1'b0}}, mdu_mag(a, signed_op)};
            mplier <= mdu_mag(b, signed_op);
            acc    <= '0;
            neg    <= signed_op & (a[XL-1] ^ b[XL-1]);   // xor of operand signs
        end
        else if (active)
        begin
            acc    <= acc + partial;
            mcand  <= {mcand[2*XL-2:0], 1'b0};
            mplier <= {1'b0, mplier[XL-1:1]};
        end
    end

    // acc stops moving once mplier is empty, so this holds until next start
    assign product = neg ? -acc : acc;

endmodule

//--- run_sim.sh
#!/usr/bin/env bash
# build with verilator and run, pass only when the pass line shows up

cd "$(dirname "$0")" &&
verilator --binary --timing --assert -f sources.f --top-module mdu_tb -o mdu_sim &&
./obj_dir/mdu_sim | tee /dev/stderr | grep -q -F '*** TEST PASSED ***' &&
echo "simulation ok" ||
{ echo "simulation failed"; exit 1; }

//--- sources.f
+incdir+hw
hw/mdu_pkg.sv
hw/apb_map_pkg.sv
hw/shift_add_mul.sv
hw/restoring_div.sv
hw/mdu_apb_regs.sv
hw/mdu_top.sv
verif/tb_clkgen.sv
verif/mdu_chk.sv
verif/mdu_tb.sv

//--- verif/mdu_chk.sv
`timescale 1ns/1ns

module mdu_chk
    import mdu_pkg::*;
(
    input logic        clk,
    input logic        rst_n,
    input logic        psel,
    input logic        penable,
    input logic        pready,
    input logic        pslverr,
    input logic        mul_start,
    input logic        div_start,
    input logic        mul_done,
    input logic        div_done,
    input mdu_status_t st
);

    a_pready: assert property (@(posedge clk) disable iff (!rst_n) pready)
        else $error("pready went low");

    a_slverr_phase: assert property (@(posedge clk) disable iff (!rst_n)
        pslverr |-> (psel && penable))
        else $error("pslverr raised outside an access phase");

    a_one_start: assert property (@(posedge clk) disable iff (!rst_n)
        !(mul_start && div_start))
        else $error("both units started in the same cycle");

    // busy may only drop right after a unit finished
    a_busy_fall: assert property (@(posedge clk) disable iff (!rst_n)
        $fell(st.busy) |-> $past(mul_done || div_done))
        else $error("busy cleared without a done pulse");

endmodule

bind mdu_top mdu_chk i_chk (
    .clk       (clk),
    .rst_n     (rst_n),
    .psel      (psel),
    .penable   (penable),
    .pready    (pready),
    .pslverr   (pslverr),
    .mul_start (mul_start),
    .div_start (div_start),
    .mul_done  (mul_done),
    .div_done  (div_done),
    .st        (i_regs.st_q)
);

//--- verif/mdu_tb.sv
`timescale 1ns/1ns
`include "mdu_cfg.svh"

module mdu_tb
    import mdu_pkg::*;
    import apb_map_pkg::*;
;

    localparam int TABLE_ROWS     = 19;
    localparam int RAND_ROWS      = 200;
    localparam int EXTRA_ROWS     = 4;       // reset, readback and bus error sequences
    localparam int TIMEOUT_CYCLES = (TABLE_ROWS + RAND_ROWS + EXTRA_ROWS) * 60 + 200;

    typedef struct packed {
        mdu_op_e   op;
        mdu_word_t a;
        mdu_word_t b;
        mdu_word_t lo;
        mdu_word_t hi;
        logic      dz;
    } vec_t;

    logic               clk;
    logic               rst_n;
    logic               psel;
    logic               penable;
    logic               pwrite;
    logic [`MDU_AW-1:0] paddr;
    logic [31:0]        pwdata;
    logic [31:0]        prdata;
    logic               pready;
    logic               pslverr;

    vec_t        rows[$];
    int          n_result_err;
    int          n_status_err;
    int          n_bus_err;
    int          cycles;
    logic [31:0] seed;
    mdu_word_t   ra;
    mdu_word_t   rb;
    mdu_op_e     rop;
    mdu_dword_t  res;
    mdu_status_t st;

    tb_clkgen #(.PERIOD(20)) i_clk (.clk(clk));

    mdu_top i_dut (
        .clk     (clk),
        .rst_n   (rst_n),
        .psel    (psel),
        .penable (penable),
        .pwrite  (pwrite),
        .paddr   (paddr),
        .pwdata  (pwdata),
        .prdata  (prdata),
        .pready  (pready),
        .pslverr (pslverr)
    );

    function automatic logic [31:0] lcg_next(input logic [31:0] s);
        return s * 32'd1664525 + 32'd1013904223;
    endfunction

    // expected {hi, lo}; divides give {remainder, quotient}
    function automatic mdu_dword_t model_result(input mdu_op_e op, input mdu_word_t a,
                                                input mdu_word_t b);
        longint sa;
        longint sb;
        int     qa;
        int     qb;
        sa = $signed(a);
        sb = $signed(b);
        qa = $signed(a);
        qb = $signed(b);
        case (op)
            MUL:     return sa * sb;
            MULU:    return {32'h0, a} * {32'h0, b};
            DIVU:    return (b == '0) ? {a, 32'hFFFF_FFFF} : {a % b, a / b};
            default:
            begin
                if (b == '0)
                    return {a, 32'hFFFF_FFFF};
                if ((a == 32'h8000_0000) && (b == 32'hFFFF_FFFF))
                    return {32'h0, 32'h8000_0000};    // signed overflow
                return {32'(qa % qb), 32'(qa / qb)};
            end
        endcase
    endfunction

    function automatic mdu_status_t done_status(input logic dz);
        mdu_status_t s;
        s.div_zero = dz;
        s.done     = 1'b1;
        s.busy     = 1'b0;
        return s;
    endfunction

    task automatic check_result(input string name, input mdu_dword_t exp, input mdu_dword_t act);
        if (act !== exp)
        begin
            $display("** Error: %s expected %h got %h", name, exp, act);
            n_result_err++;
        end
    endtask

    task automatic check_status(input string name, input mdu_status_t exp,
                                input mdu_status_t act);
        if (act !== exp)
        begin
            $display("** Error: %s expected %h got %h", name, exp, act);
            n_status_err++;
        end
    endtask

    task automatic check_err(input string name, input logic exp, input logic act);
        if (act !== exp)
        begin
            $display("** Error: %s expected %h got %h", name, exp, act);
            n_bus_err++;
        end
    endtask

    task automatic apb_write(input logic [`MDU_AW-1:0] addr, input logic [31:0] data,
                             output logic slverr);
        @(posedge clk);
        psel    <= 1'b1;     // setup phase
        penable <= 1'b0;
        pwrite  <= 1'b1;
        paddr   <= addr;
        pwdata  <= data;
        @(posedge clk);
        penable <= 1'b1;
        @(negedge clk);
        slverr = pslverr;    // mid access phase
        @(posedge clk);
        psel    <= 1'b0;
        penable <= 1'b0;
    endtask

    task automatic apb_read(input logic [`MDU_AW-1:0] addr, output logic [31:0] data,
                            output logic slverr);
        @(posedge clk);
        psel    <= 1'b1;
        penable <= 1'b0;
        pwrite  <= 1'b0;
        paddr   <= addr;
        @(posedge clk);
        penable <= 1'b1;
        @(negedge clk);
        data   = prdata;
        slverr = pslverr;
        @(posedge clk);
        psel    <= 1'b0;
        penable <= 1'b0;
    endtask

    task automatic launch_op(input mdu_op_e op, input mdu_word_t a, input mdu_word_t b);
        logic e;
        apb_write(`MDU_OFF_OPA, a, e);
        apb_write(`MDU_OFF_OPB, b, e);
        apb_write(`MDU_OFF_CTRL, 32'(op), e);
        check_err("pslverr on ctrl write", 1'b0, e);
    endtask

    task automatic wait_result(output mdu_dword_t r, output mdu_status_t s);
        logic [31:0] d;
        logic [31:0] lo;
        logic        e;
        d = '0;
        while (!d[1])        // poll for done
            apb_read(`MDU_OFF_STATUS, d, e);
        s = mdu_status_t'(d[2:0]);
        apb_read(`MDU_OFF_RES_LO, lo, e);
        apb_read(`MDU_OFF_RES_HI, d, e);
        r = {d, lo};
    endtask

    task automatic add_row(input mdu_op_e op, input mdu_word_t a, input mdu_word_t b,
                           input mdu_word_t lo, input mdu_word_t hi, input logic dz);
        vec_t v;
        v.op = op;
        v.a  = a;
        v.b  = b;
        v.lo = lo;
        v.hi = hi;
        v.dz = dz;
        rows.push_back(v);
    endtask

    task automatic load_table();
        add_row(MUL,  32'h0000_0000, 32'h0000_0005, 32'h0000_0000, 32'h0000_0000, 1'b0);
        add_row(MUL,  32'h0000_0001, 32'hFFFF_FFFF, 32'hFFFF_FFFF, 32'hFFFF_FFFF, 1'b0);
        add_row(MUL,  32'hFFFF_FFFD, 32'hFFFF_FFFB, 32'h0000_000F, 32'h0000_0000, 1'b0);
        add_row(MUL,  32'hFFFF_FFF9, 32'h0000_0006, 32'hFFFF_FFD6, 32'hFFFF_FFFF, 1'b0);
        add_row(MUL,  32'h8000_0000, 32'h8000_0000, 32'h0000_0000, 32'h4000_0000, 1'b0);
        add_row(MUL,  32'h8000_0000, 32'h0000_0001, 32'h8000_0000, 32'hFFFF_FFFF, 1'b0);
        add_row(MULU, 32'hFFFF_FFFF, 32'hFFFF_FFFF, 32'h0000_0001, 32'hFFFF_FFFE, 1'b0);
        add_row(MULU, 32'h0001_0000, 32'h0001_0000, 32'h0000_0000, 32'h0000_0001, 1'b0);
        add_row(MULU, 32'h8000_0000, 32'h0000_0002, 32'h0000_0000, 32'h0000_0001, 1'b0);
        add_row(DIV,  32'h0000_0007, 32'h0000_0002, 32'h0000_0003, 32'h0000_0001, 1'b0);
        add_row(DIV,  32'hFFFF_FFF9, 32'h0000_0002, 32'hFFFF_FFFD, 32'hFFFF_FFFF, 1'b0);
        add_row(DIV,  32'h0000_0007, 32'hFFFF_FFFE, 32'hFFFF_FFFD, 32'h0000_0001, 1'b0);
        add_row(DIV,  32'hFFFF_FFF9, 32'hFFFF_FFFE, 32'h0000_0003, 32'hFFFF_FFFF, 1'b0);
        add_row(DIVU, 32'hFFFF_FFF9, 32'h0000_0002, 32'h7FFF_FFFC, 32'h0000_0001, 1'b0);
        add_row(DIVU, 32'h0000_0064, 32'h0000_0007, 32'h0000_000E, 32'h0000_0002, 1'b0);
        add_row(DIV,  32'h0000_1234, 32'h0000_0000, 32'hFFFF_FFFF, 32'h0000_1234, 1'b1);
        add_row(DIVU, 32'hFFFF_FFF9, 32'h0000_0000, 32'hFFFF_FFFF, 32'hFFFF_FFF9, 1'b1);
        add_row(DIV,  32'h8000_0000, 32'hFFFF_FFFF, 32'h8000_0000, 32'h0000_0000, 1'b0);
        add_row(DIVU, 32'h8000_0000, 32'hFFFF_FFFF, 32'h0000_0000, 32'h8000_0000, 1'b0);
    endtask

    task automatic check_reset_values();
        logic [31:0] d;
        logic [31:0] lo;
        logic        e;
        apb_read(`MDU_OFF_STATUS, d, e);
        check_status("status after reset", '0, mdu_status_t'(d[2:0]));
        apb_read(`MDU_OFF_OPA, d, e);
        check_result("opa after reset", '0, {32'h0, d});
        apb_read(`MDU_OFF_RES_LO, lo, e);
        apb_read(`MDU_OFF_RES_HI, d, e);
        check_result("res_hi:res_lo after reset", '0, {d, lo});
        apb_write(`MDU_OFF_OPA, 32'hA5A5_5A5A, e);
        apb_write(`MDU_OFF_OPB, 32'h0123_4567, e);
        apb_read(`MDU_OFF_OPA, d, e);
        check_result("opa readback", {32'h0, 32'hA5A5_5A5A}, {32'h0, d});
        apb_read(`MDU_OFF_OPB, d, e);
        check_result("opb readback", {32'h0, 32'h0123_4567}, {32'h0, d});
    endtask

    task automatic check_bus_errors();
        logic [31:0] d;
        logic        e;
        mdu_dword_t  r;
        mdu_status_t s;
        apb_read(8'h18, d, e);
        check_err("pslverr on unmapped read", 1'b1, e);
        apb_write(8'h1C, 32'hDEAD_BEEF, e);
        check_err("pslverr on unmapped write", 1'b1, e);
        launch_op(DIVU, 32'h0000_0064, 32'h0000_0007);
        apb_write(`MDU_OFF_CTRL, 32'(MUL), e);    // divider still running
        check_err("pslverr on ctrl write while busy", 1'b1, e);
        wait_result(r, s);
        check_result("res_hi:res_lo after rejected ctrl", {32'h2, 32'hE}, r);
        check_status("status after rejected ctrl", done_status(1'b0), s);
        apb_read(`MDU_OFF_STATUS, d, e);
        check_status("status after done read", '0, mdu_status_t'(d[2:0]));
    endtask

    initial
    begin
        cycles = 0;
        while (cycles < TIMEOUT_CYCLES)
        begin
            @(posedge clk);
            cycles++;
        end
        $display("timeout: the DUT did not finish within %0d cycles", TIMEOUT_CYCLES);
        $display("*** TEST FAILED ***");
        $finish;
    end

    initial
    begin
        rst_n        = 1'b0;
        psel         = 1'b0;
        penable      = 1'b0;
        pwrite       = 1'b0;
        paddr        = '0;
        pwdata       = '0;
        n_result_err = 0;
        n_status_err = 0;
        n_bus_err    = 0;
        seed         = 32'h09e6_c430;
        load_table();
        repeat (2) @(posedge clk);
        rst_n <= 1'b1;

        check_reset_values();
        check_bus_errors();

        foreach (rows[i])
        begin
            launch_op(rows[i].op, rows[i].a, rows[i].b);
            wait_result(res, st);
            check_result($sformatf("res_hi:res_lo row %0d", i), {rows[i].hi, rows[i].lo}, res);
            check_status($sformatf("status row %0d", i), done_status(rows[i].dz), st);
        end

        for (int i = 0; i < RAND_ROWS; i++)
        begin
            seed = lcg_next(seed);
            ra   = seed;
            seed = lcg_next(seed);
            rb   = seed;
            seed = lcg_next(seed);
            rop  = mdu_op_e'(seed[17:16]);
            if (seed[30])
                rb = rb >> seed[24:20];     // shorter multipliers, varied latency
            launch_op(rop, ra, rb);
            wait_result(res, st);
            check_result($sformatf("res_hi:res_lo random %0d", i), model_result(rop, ra, rb), res);
            check_status($sformatf("status random %0d", i),
                         done_status(rop[1] && (rb == '0)), st);
        end

        $display("errors: result %0d, status %0d, pslverr %0d",
                 n_result_err, n_status_err, n_bus_err);
        if ((n_result_err + n_status_err + n_bus_err) == 0)
            $display("*** TEST PASSED ***");
        else
            $display("*** TEST FAILED ***");
        $finish;
    end

endmodule

//--- verif/tb_clkgen.sv
`timescale 1ns/1ns

module tb_clkgen #(
    parameter int PERIOD = 20
) (
    output logic clk
);

    initial
    begin
        clk = 1'b0;
    end

    always #(PERIOD / 2) clk = ~clk;    // 50 MHz

endmodule
